// File: Bender.yml
package:
  name: rvExecUnit

sources:
  - rvIsaPkg.sv
  - rvCtrlPkg.sv
  - aluDecoder.sv
  - registerFile.sv
  - alu.sv
  - instrDecode.sv
  - rvExecUnit.sv
  - target: test
    files:
      - rvExecUnit_sva.sv
      - rvExecUnit_tb.sv

// File: alu.sv
`timescale 1ns/1ps
`default_nettype none

module alu (
	input rvIsaPkg::word_t srcA,
	input rvIsaPkg::word_t srcB,
	input rvCtrlPkg::aluCtrl_t aluControl,
	output rvIsaPkg::word_t aluResult
);

	import rvIsaPkg::*;
	import rvCtrlPkg::*;

	logic [SHAMT_W-1:0] shamt;
	logic ltSigned, ltUnsigned;

	assign shamt = srcB[SHAMT_W-1:0];
	assign ltSigned = $signed(srcA) < $signed(srcB);
	assign ltUnsigned = srcA < srcB;

	always_comb begin
		case (aluControl)
			ALU_ADD: aluResult = srcA + srcB;
			ALU_SUB: aluResult = srcA - srcB;
			ALU_AND: aluResult = srcA & srcB;
			ALU_OR: aluResult = srcA | srcB;
			ALU_XOR: aluResult = srcA ^ srcB;
			ALU_SLT: aluResult = {{(XLEN-1){1'b0}}, ltSigned};
			ALU_SLTU: aluResult = {{(XLEN-1){1'b0}}, ltUnsigned};
			ALU_SLL: aluResult = srcA << shamt;
			ALU_SRL: aluResult = srcA >> shamt;
			ALU_SRA: aluResult = $signed(srcA) >>> shamt; // keeps the sign bit
			default: aluResult = '0;
		endcase
	end

endmodule

`default_nettype wire

// File: aluDecoder.sv
`timescale 1ns/1ps
`default_nettype none

module aluDecoder (
	input rvCtrlPkg::aluOp_t aluOp,
	input rvIsaPkg::funct3_t funct3,
	input logic funct7b5,
	output rvCtrlPkg::aluCtrl_t aluControl
);

	import rvCtrlPkg::*;

	logic subSel; // funct7 bit 5 picks sub, only in register form

	assign subSel = (aluOp == ALU_OP_REG) && funct7b5;

	always_comb begin
		aluControl = ALU_ADD;
		case (aluOp)
			ALU_OP_ADD: aluControl = ALU_ADD;
			ALU_OP_REG, ALU_OP_IMM: begin
				case (funct3)
					3'b000: aluControl = subSel ? ALU_SUB : ALU_ADD;
					3'b001: aluControl = ALU_SLL;
					3'b010: aluControl = ALU_SLT;
					3'b011: aluControl = ALU_SLTU;
					3'b100: aluControl = ALU_XOR;
					// both forms use bit 5 here for sra vs srl
					3'b101: aluControl = funct7b5 ? ALU_SRA : ALU_SRL;
					3'b110: aluControl = ALU_OR;
					3'b111: aluControl = ALU_AND;
					default: aluControl = ALU_ADD;
				endcase
			end
			default: aluControl = ALU_ADD; // unset class, result is discarded anyway
		endcase
	end

endmodule

`default_nettype wire

// File: instrDecode.sv
`timescale 1ns/1ps
`default_nettype none

module instrDecode (
	input logic clk,
	input logic arstN,
	input rvIsaPkg::word_t instr,
	input logic regWrite,
	input rvIsaPkg::word_t resultData,
	output rvIsaPkg::word_t srcA,
	output rvIsaPkg::word_t srcB,
	output rvCtrlPkg::aluCtrl_t aluControl,
	output logic illegal
);

	import rvIsaPkg::*;
	import rvCtrlPkg::*;

	opcode_t opcode;
	regAddr_t rd, rs1, rs2;
	funct3_t funct3;
	funct7_t funct7;
	imm_t immExt;
	aluOp_t aluOp;
	word_t readData1, readData2;
	logic wrEn;

	assign opcode = instr[6:0];

	// fields a format lacks stay zero
	always_comb begin
		rd = '0;
		rs1 = '0;
		rs2 = '0;
		funct3 = '0;
		funct7 = '0;
		case (opcode)
			OP_RTYPE: begin
				rd = instr[11:7];
				rs1 = instr[19:15];
				rs2 = instr[24:20];
				funct3 = instr[14:12];
				funct7 = instr[31:25];
			end
			OP_ITYPE_ALU: begin
				rd = instr[11:7];
				rs1 = instr[19:15];
				funct3 = instr[14:12];
				// only the shift forms carry a funct7 in imm[11:5]
				if (instr[14:12] == F3_SLL || instr[14:12] == F3_SRL_SRA)
					funct7 = instr[31:25];
			end
			OP_LUI: rd = instr[11:7];
			OP_LOAD: begin
				rd = instr[11:7];
				rs1 = instr[19:15];
				funct3 = instr[14:12];
			end
			OP_STORE, OP_BRANCH: begin
				rs1 = instr[19:15];
				rs2 = instr[24:20];
				funct3 = instr[14:12];
			end
			OP_JAL, OP_AUIPC: rd = instr[11:7];
			default: ;
		endcase
	end

	// immediate extension
	always_comb begin
		case (opcode)
			OP_ITYPE_ALU: immExt = {{20{instr[31]}}, instr[31:20]};
			OP_LUI: immExt = {instr[31:12], 12'b0};
			default: immExt = '0;
		endcase
	end

	// operation class for the ALU decoder
	always_comb begin
		case (opcode)
			OP_RTYPE: aluOp = ALU_OP_REG;
			OP_ITYPE_ALU: aluOp = ALU_OP_IMM;
			OP_LUI: aluOp = ALU_OP_ADD; // 0 + upper immediate
			default: aluOp = ALU_OP_UNSET;
		endcase
	end

	always_comb begin
		case (opcode)
			OP_RTYPE, OP_ITYPE_ALU, OP_LUI: illegal = 1'b0;
			OP_LOAD, OP_STORE, OP_BRANCH, OP_JAL, OP_AUIPC: illegal = 1'b1; // valid rv32i, not here
			default: illegal = 1'b1; // fence, system, unknown
		endcase
	end

	assign wrEn = regWrite & ~illegal; // illegal words never touch a register

	assign srcA = (opcode == OP_LUI) ? '0 : readData1;
	assign srcB = (opcode == OP_RTYPE) ? readData2 : immExt;

	aluDecoder aluDecoder_i (
		.aluOp(aluOp),
		.funct3(funct3),
		.funct7b5(funct7[5]),
		.aluControl(aluControl)
	);

	registerFile registerFile_i (
		.clk(clk),
		.arstN(arstN),
		.addr1(rs1),
		.addr2(rs2),
		.addr3(rd),
		.regWrite(wrEn),
		.dataIn(resultData),
		.readData1(readData1),
		.readData2(readData2)
	);

endmodule

`default_nettype wire

// File: registerFile.sv
`timescale 1ns/1ps
`default_nettype none

module registerFile (
	input logic clk,
	input logic arstN,
	input rvIsaPkg::regAddr_t addr1,
	input rvIsaPkg::regAddr_t addr2,
	input rvIsaPkg::regAddr_t addr3,
	input logic regWrite,
	input rvIsaPkg::word_t dataIn,
	output rvIsaPkg::word_t readData1,
	output rvIsaPkg::word_t readData2
);

	import rvIsaPkg::*;

	word_t regs [1:NUM_REGS-1]; // x0 has no storage

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			for (int i = 1; i < NUM_REGS; i++)
				regs[i] <= '0;
		end else if (regWrite && addr3 != '0) begin
			regs[addr3] <= dataIn;
		end
	end

	// x0 reads as zero
	assign readData1 = (addr1 == '0) ? '0 : regs[addr1];
	assign readData2 = (addr2 == '0) ? '0 : regs[addr2];

endmodule

`default_nettype wire

// File: rvCtrlPkg.sv
`default_nettype none

package rvCtrlPkg;

	// operation class from decode into the ALU decoder
	typedef enum logic [1:0] {
		ALU_OP_ADD,   // plain addition (lui path)
		ALU_OP_REG,   // register-register ops
		ALU_OP_IMM,   // register-immediate ops
		ALU_OP_UNSET
	} aluOp_t;

	typedef logic [3:0] aluCtrl_t;

	// ALU control codes
	localparam aluCtrl_t ALU_ADD = 4'd0;
	localparam aluCtrl_t ALU_SUB = 4'd1;
	localparam aluCtrl_t ALU_AND = 4'd2;
	localparam aluCtrl_t ALU_OR = 4'd3;
	localparam aluCtrl_t ALU_XOR = 4'd4;
	localparam aluCtrl_t ALU_SLT = 4'd5;
	localparam aluCtrl_t ALU_SLTU = 4'd6;
	localparam aluCtrl_t ALU_SLL = 4'd7;
	localparam aluCtrl_t ALU_SRL = 4'd8;
	localparam aluCtrl_t ALU_SRA = 4'd9;

	// req/ack sequencer
	typedef enum logic [1:0] {
		S_IDLE, // waiting for req
		S_EXEC, // decode, execute, write back
		S_ACK   // ack high until req drops
	} execState_t;

endpackage

`default_nettype wire

// File: rvExecUnit.f
rvIsaPkg.sv
rvCtrlPkg.sv
aluDecoder.sv
registerFile.sv
alu.sv
instrDecode.sv
rvExecUnit.sv
rvExecUnit_sva.sv
rvExecUnit_tb.sv

// File: rvExecUnit.sv
`timescale 1ns/1ps
`default_nettype none

module rvExecUnit (
	input logic clk,
	input logic arstN,
	input logic req,
	input rvIsaPkg::word_t instr,
	output logic ack,
	output rvIsaPkg::word_t result,
	output logic illegal
);

	import rvIsaPkg::*;
	import rvCtrlPkg::*;

	execState_t state;
	word_t instrReg;
	word_t srcA, srcB, aluResult;
	aluCtrl_t aluControl;
	logic decIllegal;
	logic regWrite;

	assign regWrite = (state == S_EXEC); // one write strobe per instruction

	// instruction is captured once when a request is accepted
	always_ff @(posedge clk) begin
		if (state == S_IDLE && req)
			instrReg <= instr;
	end

	// req/ack sequencer
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			state <= S_IDLE;
			ack <= 1'b0;
			result <= '0;
			illegal <= 1'b0;
		end else begin
			case (state)
				S_IDLE: if (req) state <= S_EXEC;
				S_EXEC: begin
					result <= aluResult;
					illegal <= decIllegal;
					ack <= 1'b1;
					state <= S_ACK;
				end
				S_ACK: begin
					if (!req) begin // host has seen the result
						ack <= 1'b0;
						state <= S_IDLE;
					end
				end
				default: state <= S_IDLE;
			endcase
		end
	end

	instrDecode instrDecode_i (
		.clk(clk),
		.arstN(arstN),
		.instr(instrReg),
		.regWrite(regWrite),
		.resultData(aluResult),
		.srcA(srcA),
		.srcB(srcB),
		.aluControl(aluControl),
		.illegal(decIllegal)
	);

	alu alu_i (
		.srcA(srcA),
		.srcB(srcB),
		.aluControl(aluControl),
		.aluResult(aluResult)
	);

endmodule

`default_nettype wire

// File: rvExecUnit_stimulus.txt
# columns: instruction word (hex), expected result (hex), expected illegal flag (0 or 1)
# the result column is not checked on lines whose illegal flag is 1
123450B7 12345000 0  # lui  x1, 0x12345
67808093 12345678 0  # addi x1, x1, 0x678
FFB00113 FFFFFFFB 0  # addi x2, x0, -5
0F000193 000000F0 0  # addi x3, x0, 0xf0
00400213 00000004 0  # addi x4, x0, 4
002082B3 12345673 0  # add  x5, x1, x2
40218333 000000F5 0  # sub  x6, x3, x2
0030F3B3 00000070 0  # and  x7, x1, x3
0030E433 123456F8 0  # or   x8, x1, x3
0030C4B3 12345688 0  # xor  x9, x1, x3
00312533 00000001 0  # slt  x10, x2, x3
003135B3 00000000 0  # sltu x11, x2, x3
00409633 23456780 0  # sll  x12, x1, x4
004156B3 0FFFFFFF 0  # srl  x13, x2, x4
40415733 FFFFFFFF 0  # sra  x14, x2, x4
40215793 FFFFFFFE 0  # srai x15, x2, 2
00030893 000000F5 0  # addi x17, x6, 0
07B00013 0000007B 0  # addi x0, x0, 123
00000913 00000000 0  # addi x18, x0, 0
0000A283 00000000 1  # lw   x5, 0(x1)
00028993 12345673 0  # addi x19, x5, 0
00112023 00000000 1  # sw   x1, 0(x2)
00208463 00000000 1  # beq  x1, x2, 8
00040A13 123456F8 0  # addi x20, x8, 0
010002EF 00000000 1  # jal  x5, 16
00028A93 12345673 0  # addi x21, x5, 0

// File: rvExecUnit_sva.sv
`timescale 1ns/1ps
`default_nettype none

module rvExecUnitSva (
	input logic clk,
	input logic arstN,
	input logic req,
	input logic ack
);

	int failCount = 0; // read by the testbench summary

	ackLowInReset: assert property (@(posedge clk) !arstN |-> !ack)
		else begin
			failCount++;
			$error("ack high while reset is asserted");
		end

	// host keeps req high until it sees ack
	ackNeedsReq: assert property (@(posedge clk) disable iff (!arstN) $rose(ack) |-> req)
		else begin
			failCount++;
			$error("ack rose without req");
		end

	ackFallsAfterReq: assert property (@(posedge clk) disable iff (!arstN)
			$fell(ack) |-> !$past(req))
		else begin
			failCount++;
			$error("ack fell while req was still high");
		end

	// sampled at E, EXEC at E+1, ack seen at E+2
	ackLatency: assert property (@(posedge clk) disable iff (!arstN)
			$rose(req) |-> ##2 $rose(ack))
		else begin
			failCount++;
			$error("ack did not rise two cycles after req");
		end

endmodule

`default_nettype wire

// File: rvExecUnit_tb.sv
`timescale 1ns/1ps
`default_nettype none

module rvExecUnit_tb;

	import rvIsaPkg::*;

	localparam int CLK_PERIOD = 20;
	localparam int RESET_CYCLES = 4;
	localparam int ACK_TIMEOUT = 20; // cycles allowed for either ack edge
	localparam STIM_FILE = "rvExecUnit_stimulus.txt";

	logic clk;
	logic arstN;
	logic req;
	word_t instr;
	logic ack;
	word_t result;
	logic illegal;

	int errorCount;
	int checkCount;
	int itemCount;
	logic [31:0] lcgState;
	logic timedOut;

	rvExecUnit dut_i (
		.clk(clk),
		.arstN(arstN),
		.req(req),
		.instr(instr),
		.ack(ack),
		.result(result),
		.illegal(illegal)
	);

	bind rvExecUnit rvExecUnitSva sva_i (
		.clk(clk),
		.arstN(arstN),
		.req(req),
		.ack(ack)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	function automatic logic [31:0] nextRand();
		lcgState = lcgState * 32'd1664525 + 32'd1013904223;
		return lcgState;
	endfunction

	// 0 to 3 cycles, upper bits of the LCG are the better ones
	function automatic int randomGap();
		logic [31:0] r;
		r = nextRand();
		return int'(r[17:16]);
	endfunction

	task automatic waitForAck(input logic level);
		int cycles;
		cycles = 0;
		while (ack !== level && !timedOut) begin
			@(posedge clk);
			cycles++;
			if (cycles > ACK_TIMEOUT) begin
				$display("timeout at %0t: ack did not go to %0b within %0d cycles",
					$time, level, ACK_TIMEOUT);
				timedOut = 1'b1;
			end
		end
	endtask

	task automatic checkResponse(input word_t instrIn, input word_t expResult,
			input logic expIllegal);
		checkCount++;
		if (illegal !== expIllegal) begin
			$display("FAIL at %0t: illegal = %0b, expected %0b (instr %h)",
				$time, illegal, expIllegal, instrIn);
			errorCount++;
		end
		// result of an excluded word is not defined
		if (!expIllegal && result !== expResult) begin
			$display("FAIL at %0t: result = %h, expected %h (instr %h)",
				$time, result, expResult, instrIn);
			errorCount++;
		end
	endtask

	// one four-phase transfer
	task automatic runItem(input word_t instrIn, input word_t expResult,
			input logic expIllegal);
		int gap;
		int hold;
		gap = randomGap();
		hold = randomGap();
		repeat (gap) @(posedge clk);
		@(posedge clk);
		instr <= instrIn;
		req <= 1'b1;
		waitForAck(1'b1);
		if (!timedOut) begin
			checkResponse(instrIn, expResult, expIllegal);
			repeat (hold) @(posedge clk); // host holds req, S_ACK stretches
			req <= 1'b0;
			waitForAck(1'b0);
		end
	endtask

	initial begin
		int fd;
		int fields;
		string line;
		word_t instrIn;
		word_t expResult;
		logic [31:0] expIllegal;
		errorCount = 0;
		checkCount = 0;
		itemCount = 0;
		lcgState = 32'ha4fc;
		timedOut = 1'b0;
		req = 1'b0;
		instr = '0;
		arstN = 1'b1;
		#1 arstN = 1'b0; // falling edge after time zero
		repeat (RESET_CYCLES) @(posedge clk);
		arstN <= 1'b1;
		fd = $fopen(STIM_FILE, "r");
		if (fd == 0) begin
			$display("could not open stimulus file %s", STIM_FILE);
			errorCount++;
		end else begin
			while (!timedOut && $fgets(line, fd) != 0) begin
				fields = $sscanf(line, "%h %h %h", instrIn, expResult, expIllegal);
				// comment and blank lines carry no item
				if (line.len() > 0 && line[0] != "#" && fields == 3) begin
					runItem(instrIn, expResult, expIllegal[0]);
					itemCount++;
				end
			end
			$fclose(fd);
		end
		$display("items %0d, checks %0d, errors %0d, timeouts %0d, assertion failures %0d",
			itemCount, checkCount, errorCount, timedOut, dut_i.sva_i.failCount);
		if (errorCount == 0 && !timedOut && dut_i.sva_i.failCount == 0 && itemCount > 0)
			$display("TB PASSED");
		else
			$display("TB FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// File: rvIsaPkg.sv
`default_nettype none

package rvIsaPkg;

	// base integer ISA sizes
	localparam int XLEN = 32;
	localparam int NUM_REGS = 32;
	localparam int REG_ADDR_W = $clog2(NUM_REGS);
	localparam int SHAMT_W = $clog2(XLEN); // shift amount comes from the low bits of srcB

	typedef logic [XLEN-1:0] word_t;        // instructions, operands and results
	typedef logic [REG_ADDR_W-1:0] regAddr_t;
	typedef logic [6:0] opcode_t;
	typedef logic [2:0] funct3_t;
	typedef logic [6:0] funct7_t;
	typedef logic [XLEN-1:0] imm_t;         // immediate after extension

	// opcodes the unit executes
	localparam opcode_t OP_RTYPE = 7'b0110011;
	localparam opcode_t OP_ITYPE_ALU = 7'b0010011;
	localparam opcode_t OP_LUI = 7'b0110111;

	// known opcodes with no support here (no data memory, no pc)
	localparam opcode_t OP_LOAD = 7'b0000011;
	localparam opcode_t OP_STORE = 7'b0100011;
	localparam opcode_t OP_BRANCH = 7'b1100011;
	localparam opcode_t OP_JAL = 7'b1101111;
	localparam opcode_t OP_AUIPC = 7'b0010111;

	// funct3 values of the two shift-immediate forms
	localparam funct3_t F3_SLL = 3'b001;
	localparam funct3_t F3_SRL_SRA = 3'b101;

endpackage

`default_nettype wire
